//--- hw/vd_out_pkg.sv
package vd_out_pkg;

    // ========================================================================
    // Pixel and OSD types
    // ========================================================================

    localparam int COLOR_W = 8;

    // Red in the top byte
    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    typedef logic [1:0] osd_color_t;

    // OSD palette: black, blue, yellow, white
    localparam rgb_t OSD_PALETTE_0 = '{r: 8'h00, g: 8'h00, b: 8'h00};
    localparam rgb_t OSD_PALETTE_1 = '{r: 8'h00, g: 8'h00, b: 8'hff};
    localparam rgb_t OSD_PALETTE_2 = '{r: 8'hff, g: 8'hff, b: 8'h00};
    localparam rgb_t OSD_PALETTE_3 = '{r: 8'hff, g: 8'hff, b: 8'hff};

    // ========================================================================
    // Output bus and board widths
    // ========================================================================

    // HDMI transmitter takes 12 bits per colour
    localparam int HDMI_D_W   = 36;
    localparam int HDMI_PAD_W = 4;

    // System control word
    localparam int CTRL_W        = 16;
    localparam int FRAMELOCK_BIT = 14;

    // Push buttons, plus two tied-high bits in the status vector
    localparam int KEY_W = 4;
    localparam int BTN_W = 6;

    // Resync LED stretch, roughly 0.6 s at 27 MHz
    localparam int STRETCH_W_DEFAULT = 24;

endpackage

//--- hw/osd_overlay.sv
`timescale 1ns/1ps

module osd_overlay (
    input  logic                   pclk_out,
    input  logic                   sys_reset_n,

    // Scaler stream
    input  vd_out_pkg::rgb_t       sc_pixel_i,
    input  logic                   sc_hsync_i,
    input  logic                   sc_vsync_i,
    input  logic                   sc_de_i,

    // OSD generator
    input  logic                   osd_enable_i,
    input  vd_out_pkg::osd_color_t osd_color_i,

    // Overlaid stream, one cycle later
    output vd_out_pkg::rgb_t       ov_pixel_o,
    output logic                   ov_hsync_o,
    output logic                   ov_vsync_o,
    output logic                   ov_de_o
);

    // ========================================================================
    // Palette lookup
    // ========================================================================

    vd_out_pkg::rgb_t osd_rgb;
    vd_out_pkg::rgb_t mux_rgb;

    always_comb begin
        case (osd_color_i)
            2'd0: begin
                osd_rgb = vd_out_pkg::OSD_PALETTE_0;
            end
            2'd1: begin
                osd_rgb = vd_out_pkg::OSD_PALETTE_1;
            end
            2'd2: begin
                osd_rgb = vd_out_pkg::OSD_PALETTE_2;
            end
            default: begin
                osd_rgb = vd_out_pkg::OSD_PALETTE_3;
            end
        endcase
    end

    // OSD wins over the scaler pixel
    always_comb begin
        if (osd_enable_i) begin
            mux_rgb = osd_rgb;
        end else begin
            mux_rgb = sc_pixel_i;
        end
    end

    // ========================================================================
    // Output register
    // ========================================================================

    // Syncs and DE ride along so they stay with their pixel
    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            ov_pixel_o <= '0;
            ov_hsync_o <= 1'b0;
            ov_vsync_o <= 1'b0;
            ov_de_o    <= 1'b0;
        end else begin
            ov_pixel_o <= mux_rgb;
            ov_hsync_o <= sc_hsync_i;
            ov_vsync_o <= sc_vsync_i;
            ov_de_o    <= sc_de_i;
        end
    end

endmodule

//--- hw/video_out_launch.sv
`timescale 1ns/1ps

module video_out_launch (
    input  logic                              pclk_out,
    input  logic                              sys_reset_n,

    // Overlaid stream
    input  vd_out_pkg::rgb_t                  ov_pixel_i,
    input  logic                              ov_hsync_i,
    input  logic                              ov_vsync_i,
    input  logic                              ov_de_i,

    // HDMI transmitter
    output logic [vd_out_pkg::HDMI_D_W-1:0]   hdmi_d_o,
    output logic                              hdmi_hs_o,
    output logic                              hdmi_vs_o,
    output logic                              hdmi_de_o,

    // VGA DAC
    output logic [vd_out_pkg::COLOR_W-1:0]    vga_r_o,
    output logic [vd_out_pkg::COLOR_W-1:0]    vga_g_o,
    output logic [vd_out_pkg::COLOR_W-1:0]    vga_b_o,
    output logic                              vga_hs_o,
    output logic                              vga_vs_o,
    output logic                              vga_blank_n_o,
    output logic                              vga_sync_n_o
);

    localparam logic [vd_out_pkg::HDMI_PAD_W-1:0] PAD = '0;

    logic [vd_out_pkg::HDMI_D_W-1:0] hdmi_word;

    // 8-bit colours sit in the top of each 12-bit lane
    assign hdmi_word = {ov_pixel_i.r, PAD, ov_pixel_i.g, PAD, ov_pixel_i.b, PAD};

    // ========================================================================
    // HDMI launch, rising edge
    // ========================================================================

    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hdmi_d_o  <= '0;
            hdmi_hs_o <= 1'b0;
            hdmi_vs_o <= 1'b0;
            hdmi_de_o <= 1'b0;
        end else begin
            hdmi_d_o  <= hdmi_word;
            hdmi_hs_o <= ov_hsync_i;
            hdmi_vs_o <= ov_vsync_i;
            hdmi_de_o <= ov_de_i;
        end
    end

    // ========================================================================
    // VGA launch, falling edge
    // ========================================================================

    // Half a cycle of margin towards the DAC
    always_ff @(negedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            vga_r_o       <= '0;
            vga_g_o       <= '0;
            vga_b_o       <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
        end else begin
            vga_r_o       <= ov_pixel_i.r;
            vga_g_o       <= ov_pixel_i.g;
            vga_b_o       <= ov_pixel_i.b;
            vga_hs_o      <= ov_hsync_i;
            vga_vs_o      <= ov_vsync_i;
            vga_blank_n_o <= ov_de_i;
        end
    end

    // No sync-on-green
    assign vga_sync_n_o = 1'b0;

endmodule

//--- hw/panel_status.sv
`timescale 1ns/1ps

// Two-flop synchronizer, idles high like the panel inputs
module vd_sync2 #(
    parameter type T = logic
) (
    input  logic pclk_out,
    input  logic sys_reset_n,
    input  T     d_i,
    output T     q_o
);

    T meta;

    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            meta <= '1;
            q_o  <= '1;
        end else begin
            meta <= d_i;
            q_o  <= meta;
        end
    end

endmodule

module panel_status #(
    parameter int STRETCH_W = vd_out_pkg::STRETCH_W_DEFAULT
) (
    input  logic                           pclk_out,
    input  logic                           sys_reset_n,
    input  logic [vd_out_pkg::KEY_W-1:0]   key_i,
    input  logic                           ir_rx_i,
    input  logic                           resync_strobe_i,
    output logic [vd_out_pkg::BTN_W-1:0]   btn_o,
    output logic                           ir_rx_o,
    output logic                           resync_led_o
);

    // ========================================================================
    // Button and IR synchronizers
    // ========================================================================

    logic [vd_out_pkg::BTN_W-1:0] btn_raw;

    // Keys on top, spare bits tied high
    assign btn_raw = {key_i, {(vd_out_pkg::BTN_W - vd_out_pkg::KEY_W){1'b1}}};

    vd_sync2 #(
        .T (logic [vd_out_pkg::BTN_W-1:0])
    ) u_btn_sync (
        .pclk_out    (pclk_out),
        .sys_reset_n (sys_reset_n),
        .d_i         (btn_raw),
        .q_o         (btn_o)
    );

    vd_sync2 #(
        .T (logic)
    ) u_ir_sync (
        .pclk_out    (pclk_out),
        .sys_reset_n (sys_reset_n),
        .d_i         (ir_rx_i),
        .q_o         (ir_rx_o)
    );

    // ========================================================================
    // Resync LED stretcher
    // ========================================================================

    logic                 strobe_sync1;
    logic                 strobe_sync2;
    logic                 strobe_prev;
    logic [STRETCH_W-1:0] led_ctr;

    always_ff @(posedge pclk_out or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            strobe_sync1 <= 1'b0;
            strobe_sync2 <= 1'b0;
            strobe_prev  <= 1'b0;
            led_ctr      <= '0;
        end else begin
            strobe_sync1 <= resync_strobe_i;
            strobe_sync2 <= strobe_sync1;
            strobe_prev  <= strobe_sync2;
            // Rising edge only, a held level just lets it run out
            if (strobe_sync2 && !strobe_prev) begin
                led_ctr <= '1;
            end else if (led_ctr != '0) begin
                led_ctr <= led_ctr - 1'b1;
            end
        end
    end

    assign resync_led_o = (led_ctr != '0);

endmodule

//--- hw/vd_out_top.sv
`timescale 1ns/1ps

module vd_out_top #(
    parameter int STRETCH_W = vd_out_pkg::STRETCH_W_DEFAULT
) (
    input  logic                              pclk_out,
    input  logic                              sys_reset_n,

    // Scaler stream and OSD
    input  vd_out_pkg::rgb_t                  sc_pixel_i,
    input  logic                              sc_hsync_i,
    input  logic                              sc_vsync_i,
    input  logic                              sc_de_i,
    input  logic                              osd_enable_i,
    input  vd_out_pkg::osd_color_t            osd_color_i,

    // System control and front panel
    input  logic [vd_out_pkg::CTRL_W-1:0]     sys_ctrl_i,
    input  logic [vd_out_pkg::KEY_W-1:0]      key_i,
    input  logic                              ir_rx_i,
    input  logic                              resync_strobe_i,

    // HDMI transmitter
    output logic [vd_out_pkg::HDMI_D_W-1:0]   hdmi_d_o,
    output logic                              hdmi_hs_o,
    output logic                              hdmi_vs_o,
    output logic                              hdmi_de_o,

    // VGA DAC
    output logic [vd_out_pkg::COLOR_W-1:0]    vga_r_o,
    output logic [vd_out_pkg::COLOR_W-1:0]    vga_g_o,
    output logic [vd_out_pkg::COLOR_W-1:0]    vga_b_o,
    output logic                              vga_hs_o,
    output logic                              vga_vs_o,
    output logic                              vga_blank_n_o,
    output logic                              vga_sync_n_o,

    // Panel status
    output logic [vd_out_pkg::BTN_W-1:0]      btn_o,
    output logic                              ir_rx_o,
    output logic                              resync_led_o,
    output logic                              framelock_led_o
);

    // ========================================================================
    // Video output path
    // ========================================================================

    vd_out_pkg::rgb_t ov_pixel;
    logic             ov_hsync;
    logic             ov_vsync;
    logic             ov_de;

    osd_overlay u_osd_overlay (
        .pclk_out     (pclk_out),
        .sys_reset_n  (sys_reset_n),
        .sc_pixel_i   (sc_pixel_i),
        .sc_hsync_i   (sc_hsync_i),
        .sc_vsync_i   (sc_vsync_i),
        .sc_de_i      (sc_de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .ov_pixel_o   (ov_pixel),
        .ov_hsync_o   (ov_hsync),
        .ov_vsync_o   (ov_vsync),
        .ov_de_o      (ov_de)
    );

    video_out_launch u_video_out_launch (
        .pclk_out      (pclk_out),
        .sys_reset_n   (sys_reset_n),
        .ov_pixel_i    (ov_pixel),
        .ov_hsync_i    (ov_hsync),
        .ov_vsync_i    (ov_vsync),
        .ov_de_i       (ov_de),
        .hdmi_d_o      (hdmi_d_o),
        .hdmi_hs_o     (hdmi_hs_o),
        .hdmi_vs_o     (hdmi_vs_o),
        .hdmi_de_o     (hdmi_de_o),
        .vga_r_o       (vga_r_o),
        .vga_g_o       (vga_g_o),
        .vga_b_o       (vga_b_o),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o),
        .vga_blank_n_o (vga_blank_n_o),
        .vga_sync_n_o  (vga_sync_n_o)
    );

    // ========================================================================
    // Front panel
    // ========================================================================

    panel_status #(
        .STRETCH_W (STRETCH_W)
    ) u_panel_status (
        .pclk_out        (pclk_out),
        .sys_reset_n     (sys_reset_n),
        .key_i           (key_i),
        .ir_rx_i         (ir_rx_i),
        .resync_strobe_i (resync_strobe_i),
        .btn_o           (btn_o),
        .ir_rx_o         (ir_rx_o),
        .resync_led_o    (resync_led_o)
    );

    // Framelock straight from the control word
    assign framelock_led_o = sys_ctrl_i[vd_out_pkg::FRAMELOCK_BIT];

endmodule

//--- testbench/tb_vd_out_ref.svh
`ifndef TB_VD_OUT_REF_SVH
`define TB_VD_OUT_REF_SVH

// Strobe drive edge to first LED-high sample: input sample plus two sync flops
localparam int LED_RISE_CYCLES = 3;
localparam int HDMI_W_TB       = 3 * (vd_out_pkg::COLOR_W + vd_out_pkg::HDMI_PAD_W);

// Colour leaving the overlay stage
function automatic vd_out_pkg::rgb_t exp_pixel(input vd_out_pkg::rgb_t pix,
                                               input logic osd_en, input logic [1:0] idx);
    vd_out_pkg::rgb_t c;
    c = pix;
    if (osd_en) begin
        case (idx)
            2'd0: c = vd_out_pkg::OSD_PALETTE_0;
            2'd1: c = vd_out_pkg::OSD_PALETTE_1;
            2'd2: c = vd_out_pkg::OSD_PALETTE_2;
            default: c = vd_out_pkg::OSD_PALETTE_3;
        endcase
    end
    return c;
endfunction

// Each colour in the top of a 12-bit lane, pad nibble below it
function automatic logic [HDMI_W_TB-1:0] exp_hdmi_word(input vd_out_pkg::rgb_t pix,
                                                       input logic osd_en,
                                                       input logic [1:0] idx);
    vd_out_pkg::rgb_t c;
    c = exp_pixel(pix, osd_en, idx);
    return {c.r, {vd_out_pkg::HDMI_PAD_W{1'b0}}, c.g, {vd_out_pkg::HDMI_PAD_W{1'b0}},
            c.b, {vd_out_pkg::HDMI_PAD_W{1'b0}}};
endfunction

function automatic logic [3*vd_out_pkg::COLOR_W-1:0] exp_vga_color(
    input vd_out_pkg::rgb_t pix, input logic osd_en, input logic [1:0] idx);
    vd_out_pkg::rgb_t c;
    c = exp_pixel(pix, osd_en, idx);
    return {c.r, c.g, c.b};
endfunction

function automatic int exp_led_len(input int stretch_w);
    return (1 << stretch_w) - 1;
endfunction

// Second edge driven restart_at samples into the pulse
function automatic int exp_led_restart_len(input int stretch_w, input int restart_at);
    return restart_at - 1 + LED_RISE_CYCLES + exp_led_len(stretch_w);
endfunction

function automatic logic [5:0] exp_btn(input logic [3:0] key);
    return {key, 2'b11};
endfunction

`endif

//--- testbench/tb_vd_out.sv
`timescale 1ns/1ps

module tb_vd_out;

    localparam int STRETCH_W_TB      = 6;
    localparam int FRAMELOCK_BIT_TB  = 14;
    localparam int N_RANDOM          = 400;
    localparam int N_OSD_EACH        = 50;
    localparam int RESTART_AT        = 20;
    localparam int HOLD_EXTRA        = 20;
    localparam int LED_TEST_CYCLES   = 3 * ((1 << STRETCH_W_TB) + RESTART_AT + HOLD_EXTRA);
    localparam int PANEL_TEST_CYCLES = 2 * 16 + 2 * 8 + 16;
    localparam int TEST_CYCLES       = 2 + N_RANDOM + 4 * N_OSD_EACH + 8
                                       + LED_TEST_CYCLES + PANEL_TEST_CYCLES;
    localparam int TIMEOUT_CYCLES    = 3 * TEST_CYCLES;

    typedef struct packed {
        logic                   chk;
        vd_out_pkg::rgb_t       pix;
        logic                   hs;
        logic                   vs;
        logic                   de;
        logic                   osd_en;
        vd_out_pkg::osd_color_t idx;
    } vid_sample_t;

    `include "tb_vd_out_ref.svh"

    logic                            pclk_out;
    logic                            sys_reset_n;
    vd_out_pkg::rgb_t                sc_pixel_i;
    logic                            sc_hsync_i;
    logic                            sc_vsync_i;
    logic                            sc_de_i;
    logic                            osd_enable_i;
    vd_out_pkg::osd_color_t          osd_color_i;
    logic [vd_out_pkg::CTRL_W-1:0]   sys_ctrl_i;
    logic [vd_out_pkg::KEY_W-1:0]    key_i;
    logic                            ir_rx_i;
    logic                            resync_strobe_i;
    logic [vd_out_pkg::HDMI_D_W-1:0] hdmi_d_o;
    logic                            hdmi_hs_o;
    logic                            hdmi_vs_o;
    logic                            hdmi_de_o;
    logic [vd_out_pkg::COLOR_W-1:0]  vga_r_o;
    logic [vd_out_pkg::COLOR_W-1:0]  vga_g_o;
    logic [vd_out_pkg::COLOR_W-1:0]  vga_b_o;
    logic                            vga_hs_o;
    logic                            vga_vs_o;
    logic                            vga_blank_n_o;
    logic                            vga_sync_n_o;
    logic [vd_out_pkg::BTN_W-1:0]    btn_o;
    logic                            ir_rx_o;
    logic                            resync_led_o;
    logic                            framelock_led_o;

    logic        video_chk;
    string       current_test;
    int          cycle_count;
    vid_sample_t hist[$];
    string       hist_name[$];

    vd_out_top #(
        .STRETCH_W (STRETCH_W_TB)
    ) DUT (.*);

    initial begin
        pclk_out = 1'b0;
        forever begin
            #4 pclk_out = ~pclk_out;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge pclk_out);
            cycle_count++;
        end
        $display("Timeout: tests still running after %0d cycles", cycle_count);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    task automatic tick();
        @(posedge pclk_out);
        #1;
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH test=%s %s expected=%0h actual=%0h",
                     test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_reset_values();
        check_value(current_test, "hdmi outputs", 64'h0,
                    64'({hdmi_d_o, hdmi_hs_o, hdmi_vs_o, hdmi_de_o}));
        check_value(current_test, "vga outputs", 64'h0, 64'({vga_r_o, vga_g_o, vga_b_o,
                    vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o}));
        check_value(current_test, "resync_led_o", 64'h0, 64'(resync_led_o));
        check_value(current_test, "btn_o", 64'(6'h3f), 64'(btn_o));
        check_value(current_test, "ir_rx_o", 64'(1'b1), 64'(ir_rx_o));
    endtask

    task automatic drive_stream(input int count, input logic osd_en, input logic [1:0] idx);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            tick();
            rnd          = $urandom();
            sc_pixel_i   = rnd[23:0];
            sc_hsync_i   = rnd[24];
            sc_vsync_i   = rnd[25];
            sc_de_i      = rnd[26];
            osd_enable_i = osd_en;
            osd_color_i  = osd_en ? idx : rnd[28:27];
            video_chk    = 1'b1;
        end
    endtask

    // Counts cycles to LED rise and LED-high samples after a strobe edge
    // A set hold keeps the strobe level up
    task automatic measure_led(input int restart_at, input logic hold,
                               output int rise, output int width);
        resync_strobe_i = 1'b1;
        rise = 0;
        while (!resync_led_o && rise < 16) begin
            tick();
            rise++;
            resync_strobe_i = hold;
        end
        width = 0;
        while (resync_led_o) begin
            width++;
            resync_strobe_i = hold || (width == restart_at);
            tick();
        end
    endtask

    // ========================================================================
    // Compare process
    // ========================================================================

    // HDMI lags the inputs by two cycles and VGA by one and a half
    initial begin : compare_outputs
        vid_sample_t s;
        forever begin
            @(posedge pclk_out);
            #2;
            s.chk    = video_chk;
            s.pix    = sc_pixel_i;
            s.hs     = sc_hsync_i;
            s.vs     = sc_vsync_i;
            s.de     = sc_de_i;
            s.osd_en = osd_enable_i;
            s.idx    = osd_color_i;
            hist.push_front(s);
            hist_name.push_front(current_test);
            if (hist.size() > 3) begin
                void'(hist.pop_back());
                void'(hist_name.pop_back());
            end
            if (hist.size() == 3 && hist[2].chk) begin
                check_value(hist_name[2], "hdmi_d_o",
                            64'(exp_hdmi_word(hist[2].pix, hist[2].osd_en, hist[2].idx)),
                            64'(hdmi_d_o));
                check_value(hist_name[2], "hdmi hs/vs/de",
                            64'({hist[2].hs, hist[2].vs, hist[2].de}),
                            64'({hdmi_hs_o, hdmi_vs_o, hdmi_de_o}));
            end
            #4;
            if (hist.size() >= 2 && hist[1].chk) begin
                check_value(hist_name[1], "vga rgb",
                            64'(exp_vga_color(hist[1].pix, hist[1].osd_en, hist[1].idx)),
                            64'({vga_r_o, vga_g_o, vga_b_o}));
                check_value(hist_name[1], "vga hs/vs/blank_n/sync_n",
                            64'({hist[1].hs, hist[1].vs, hist[1].de, 1'b0}),
                            64'({vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o}));
            end
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    initial begin : stimulus
        int          rise;
        int          width;
        logic [3:0]  prev_key;
        logic        prev_ir;
        logic [31:0] rnd;
        void'($urandom(32'he6e8_8725));
        sys_reset_n     = 1'b0;
        sc_pixel_i      = '0;
        sc_hsync_i      = 1'b0;
        sc_vsync_i      = 1'b0;
        sc_de_i         = 1'b0;
        osd_enable_i    = 1'b0;
        osd_color_i     = '0;
        sys_ctrl_i      = '0;
        key_i           = 4'hf;
        ir_rx_i         = 1'b1;
        resync_strobe_i = 1'b0;
        video_chk       = 1'b0;
        current_test    = "reset";
        repeat (2) @(posedge pclk_out);
        #1;
        sys_reset_n = 1'b1;
        check_reset_values();

        current_test = "osd_off_stream";
        drive_stream(N_RANDOM, 1'b0, 2'd0);
        for (int idx = 0; idx < 4; idx++) begin
            current_test = $sformatf("osd_index_%0d", idx);
            drive_stream(N_OSD_EACH, 1'b1, 2'(idx));
        end
        tick();
        video_chk = 1'b0;
        repeat (2) tick();

        current_test = "led_single_edge";
        measure_led(0, 1'b0, rise, width);
        check_value(current_test, "rise cycles", 64'(LED_RISE_CYCLES), 64'(rise));
        check_value(current_test, "pulse cycles", 64'(exp_led_len(STRETCH_W_TB)), 64'(width));
        repeat (8) tick();
        current_test = "led_restart";
        measure_led(RESTART_AT, 1'b0, rise, width);
        check_value(current_test, "rise cycles", 64'(LED_RISE_CYCLES), 64'(rise));
        check_value(current_test, "pulse cycles",
                    64'(exp_led_restart_len(STRETCH_W_TB, RESTART_AT)), 64'(width));
        repeat (8) tick();
        current_test = "led_held_level";
        measure_led(0, 1'b1, rise, width);
        check_value(current_test, "rise cycles", 64'(LED_RISE_CYCLES), 64'(rise));
        check_value(current_test, "pulse cycles", 64'(exp_led_len(STRETCH_W_TB)), 64'(width));
        repeat (HOLD_EXTRA) begin
            tick();
            check_value(current_test, "no retrigger", 64'h0, 64'(resync_led_o));
        end
        resync_strobe_i = 1'b0;
        repeat (4) tick();

        current_test = "buttons";
        prev_key = key_i;
        for (int k = 0; k < 16; k++) begin
            key_i = 4'(k);
            tick();
            check_value(current_test, "btn_o first cycle", 64'(exp_btn(prev_key)), 64'(btn_o));
            tick();
            check_value(current_test, "btn_o", 64'(exp_btn(key_i)), 64'(btn_o));
            prev_key = key_i;
        end
        current_test = "ir_line";
        prev_ir = ir_rx_i;
        repeat (8) begin
            rnd     = $urandom();
            ir_rx_i = rnd[0];
            tick();
            check_value(current_test, "ir_rx_o first cycle", 64'(prev_ir), 64'(ir_rx_o));
            tick();
            check_value(current_test, "ir_rx_o", 64'(ir_rx_i), 64'(ir_rx_o));
            prev_ir = ir_rx_i;
        end
        current_test = "framelock";
        repeat (16) begin
            rnd        = $urandom();
            sys_ctrl_i = rnd[15:0];
            #1;
            check_value(current_test, "framelock_led_o",
                        64'(sys_ctrl_i[FRAMELOCK_BIT_TB]), 64'(framelock_led_o));
            tick();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- build.f
+incdir+testbench
hw/vd_out_pkg.sv
hw/osd_overlay.sv
hw/video_out_launch.sv
hw/panel_status.sv
hw/vd_out_top.sv
testbench/tb_vd_out.sv

//--- Makefile
TOOL      ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_vd_out
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
